/* Makefile */
TOP := ex_stage_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ns -f compile.f --top-module $(TOP) \
		-Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+src
src/ex_ctrl_pkg.sv
src/ex_data_pkg.sv
src/ex_issue_reg.sv
src/ex_alu.sv
src/ex_next_pc.sv
src/ex_store_format.sv
src/ex_stage.sv
verif/ex_tb_clock.sv
verif/ex_stage_tb.sv

/* src/ex_alu.sv */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_alu
    import ex_ctrl_pkg::*;
(
    input  logic [`EX_XLEN-1:0] a,
    input  logic [`EX_XLEN-1:0] b,
    input  alu_op_t             op,
    input  logic                word_op,
    output logic [`EX_XLEN-1:0] result,
    output logic                zero
);

    logic [31:0]         a_lo;
    logic [4:0]          shamt_w;
    logic [5:0]          shamt_d;
    logic [`EX_XLEN-1:0] sll_res;
    logic [`EX_XLEN-1:0] srl_res;
    logic [`EX_XLEN-1:0] sra_res;
    logic [`EX_XLEN-1:0] raw;

    assign a_lo    = a[31:0];
    assign shamt_w = b[4:0];
    assign shamt_d = b[5:0];

    // Word shifts act on the low half only, upper bits are fixed up below
    always_comb begin
        if (word_op) begin
            sll_res = {32'd0, a_lo << shamt_w};
            srl_res = {32'd0, a_lo >> shamt_w};
            sra_res = {32'd0, $unsigned($signed(a_lo) >>> shamt_w)};
        end else begin
            sll_res = a << shamt_d;
            srl_res = a >> shamt_d;
            sra_res = $unsigned($signed(a) >>> shamt_d);
        end
    end

    always_comb begin
        case (op)
            ALU_ADD: begin
                raw = a + b;
            end
            ALU_SUB: begin
                raw = a - b;
            end
            ALU_SLL: begin
                raw = sll_res;
            end
            ALU_SLT: begin
                raw = {63'd0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                raw = {63'd0, a < b};
            end
            ALU_XOR: begin
                raw = a ^ b;
            end
            ALU_SRL: begin
                raw = srl_res;
            end
            ALU_SRA: begin
                raw = sra_res;
            end
            ALU_OR: begin
                raw = a | b;
            end
            ALU_AND: begin
                raw = a & b;
            end
            ALU_PASS_B: begin
                raw = b;
            end
            default: begin
                raw = '0;
            end
        endcase
    end

    // addw, subw and the shift words all sign-extend from bit 31
    assign result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;
    assign zero   = (result == '0);

endmodule

/* src/ex_config.svh */
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data path and program counter width
`define EX_XLEN 64

// Raw immediate as delivered by decode, sign-extended in the execute stage
`define EX_IMM_W 32

// Architectural register index width
`define EX_REG_AW 5

// CSR address width
`define EX_CSR_AW 12

`endif

/* src/ex_ctrl_pkg.sv */
`include "ex_config.svh"

package ex_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // Used by lui and CSR reads
    } alu_op_t;

    typedef enum logic {
        A_RS1 = 1'b0,
        A_PC  = 1'b1
    } alu_a_sel_t;

    typedef enum logic [1:0] {
        B_RS2  = 2'd0,
        B_FOUR = 2'd1,
        B_IMM  = 2'd2,
        B_CSR  = 2'd3
    } alu_b_sel_t;

    // Unsigned branches reuse BLT and BGE with the ALU set to sltu
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_JAL  = 3'd1,
        BR_JALR = 3'd2,
        BR_BEQ  = 3'd3,
        BR_BNE  = 3'd4,
        BR_BLT  = 3'd5,
        BR_BGE  = 3'd6
    } branch_t;

    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2,
        MEM_D = 2'd3
    } mem_size_t;

    typedef struct packed {
        alu_op_t                 alu_op;
        logic                    word_op; // Sign-extend low 32 bits of result
        alu_a_sel_t              a_sel;
        alu_b_sel_t              b_sel;
        branch_t                 branch;
        logic                    mem_rd;
        logic                    mem_wr;
        mem_size_t               mem_size;
        logic                    reg_wr;
        logic [`EX_REG_AW-1:0]   rd;
        logic                    csr;
        logic [`EX_CSR_AW-1:0]   csr_addr;
        logic                    ecall;
        logic                    mret;
        logic                    fence_i;
        logic                    error;
    } ex_ctrl_t;

endpackage

/* src/ex_data_pkg.sv */
`include "ex_config.svh"

package ex_data_pkg;

    import ex_ctrl_pkg::*;

    typedef struct packed {
        logic [`EX_XLEN-1:0]  src1;
        logic [`EX_XLEN-1:0]  src2;
        logic [`EX_IMM_W-1:0] imm;
        logic [`EX_XLEN-1:0]  csr_data;
        logic [`EX_XLEN-1:0]  pc;
    } ex_operands_t;

    // One decoded instruction as held by the issue register
    typedef struct packed {
        ex_ctrl_t     ctrl;
        ex_operands_t ops;
    } ex_issue_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]   result;
        logic [`EX_REG_AW-1:0] rd;
        logic                  reg_wr;
        logic                  csr;
        logic [`EX_CSR_AW-1:0] csr_addr;
        logic                  ecall;
        logic                  mret;
        logic                  error;
        logic                  is_alu; // Result is final, no load data follows
    } ex_result_t;

    typedef struct packed {
        logic                taken;
        logic [`EX_XLEN-1:0] target; // Next PC even when not taken
    } ex_jump_t;

    typedef struct packed {
        logic                wr;
        logic [`EX_XLEN-1:0] addr;
        logic [`EX_XLEN-1:0] data;
        logic [7:0]          mask;
    } ex_store_t;

endpackage

/* src/ex_issue_reg.sv */
`timescale 1ns/1ns

module ex_issue_reg
    import ex_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  logic      in_valid,
    input  ex_issue_t in_issue,
    output logic      valid,
    output ex_issue_t issue
);

    // The valid bit is the only control state of the slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= in_valid;
        end
    end

    // Payload follows the same hold rule as valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            issue <= in_issue;
        end
    end

endmodule

/* src/ex_next_pc.sv */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_next_pc
    import ex_ctrl_pkg::*;
    import ex_data_pkg::*;
(
    input  logic [`EX_XLEN-1:0] pc,
    input  logic [`EX_XLEN-1:0] src1,
    input  logic [`EX_XLEN-1:0] imm,
    input  logic                zero,
    input  logic                result_lsb,
    input  logic                fence_i,
    input  branch_t             branch,
    output ex_jump_t            jump
);

    logic [`EX_XLEN-1:0] pc_plus_imm;
    logic [`EX_XLEN-1:0] pc_plus_4;
    logic [`EX_XLEN-1:0] jalr_sum;
    logic                cond;

    assign pc_plus_imm = pc + imm;
    assign pc_plus_4   = pc + `EX_XLEN'd4;
    assign jalr_sum    = src1 + imm;

    // Conditional branches read the flags of the sub or slt result
    always_comb begin
        case (branch)
            BR_BEQ:  cond = zero;
            BR_BNE:  cond = !zero;
            BR_BLT:  cond = result_lsb;
            BR_BGE:  cond = !result_lsb;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        if (fence_i) begin
            jump.taken  = 1'b1; // Refetch everything after the fence
            jump.target = pc_plus_4;
        end else if (branch == BR_JAL) begin
            jump.taken  = 1'b1;
            jump.target = pc_plus_imm;
        end else if (branch == BR_JALR) begin
            jump.taken  = 1'b1;
            jump.target = {jalr_sum[`EX_XLEN-1:1], 1'b0};
        end else begin
            jump.taken  = cond;
            jump.target = cond ? pc_plus_imm : pc_plus_4;
        end
    end

endmodule

/* src/ex_stage.sv */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_stage
    import ex_ctrl_pkg::*;
    import ex_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       in_valid,
    input  logic       raise_intr,
    input  ex_issue_t  in_issue,
    output logic       out_valid,
    output ex_result_t out_res,
    output ex_jump_t   out_jump,
    output ex_store_t  out_store
);

    ex_issue_t           issue;
    logic                issue_valid;
    logic [`EX_XLEN-1:0] imm_ext;
    logic [`EX_XLEN-1:0] op_a;
    logic [`EX_XLEN-1:0] op_b;
    logic [`EX_XLEN-1:0] alu_result;
    logic                zero;
    ex_jump_t            jump_raw;

    ex_issue_reg u_issue_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .in_valid (in_valid),
        .in_issue (in_issue),
        .valid    (issue_valid),
        .issue    (issue)
    );

    assign imm_ext = {{(`EX_XLEN - `EX_IMM_W){issue.ops.imm[`EX_IMM_W-1]}}, issue.ops.imm};
    assign op_a    = (issue.ctrl.a_sel == A_PC) ? issue.ops.pc : issue.ops.src1;

    always_comb begin
        case (issue.ctrl.b_sel)
            B_RS2:   op_b = issue.ops.src2;
            B_FOUR:  op_b = `EX_XLEN'd4; // Link address for jal and jalr
            B_IMM:   op_b = imm_ext;
            default: op_b = issue.ops.csr_data;
        endcase
    end

    ex_alu u_alu (
        .a       (op_a),
        .b       (op_b),
        .op      (issue.ctrl.alu_op),
        .word_op (issue.ctrl.word_op),
        .result  (alu_result),
        .zero    (zero)
    );

    ex_next_pc u_next_pc (
        .pc         (issue.ops.pc),
        .src1       (issue.ops.src1),
        .imm        (imm_ext),
        .zero       (zero),
        .result_lsb (alu_result[0]),
        .fence_i    (issue.ctrl.fence_i),
        .branch     (issue.ctrl.branch),
        .jump       (jump_raw)
    );

    // An empty slot must never write memory
    ex_store_format u_store_format (
        .wr    (issue.ctrl.mem_wr && issue_valid),
        .size  (issue.ctrl.mem_size),
        .addr  (alu_result),
        .wdata (issue.ops.src2),
        .store (out_store)
    );

    // ecall still retires so the trap is taken with the right cause
    assign out_valid = issue_valid && (issue.ctrl.ecall || !raise_intr);

    assign out_jump.taken  = jump_raw.taken && issue_valid;
    assign out_jump.target = jump_raw.target;

    assign out_res.result   = alu_result;
    assign out_res.rd       = issue.ctrl.rd;
    assign out_res.reg_wr   = issue.ctrl.reg_wr;
    assign out_res.csr      = issue.ctrl.csr;
    assign out_res.csr_addr = issue.ctrl.csr_addr;
    assign out_res.ecall    = issue.ctrl.ecall;
    assign out_res.mret     = issue.ctrl.mret;
    assign out_res.error    = issue.ctrl.error;
    assign out_res.is_alu   = !issue.ctrl.mem_rd;

endmodule

/* src/ex_store_format.sv */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_store_format
    import ex_ctrl_pkg::*;
    import ex_data_pkg::*;
(
    input  logic                wr,
    input  mem_size_t           size,
    input  logic [`EX_XLEN-1:0] addr,
    input  logic [`EX_XLEN-1:0] wdata,
    output ex_store_t           store
);

    logic [`EX_XLEN-1:0] lane_data;
    logic [7:0]          lane_mask;

    // Data is copied to every lane so memory only needs the mask
    always_comb begin
        case (size)
            MEM_B: begin
                lane_data = {8{wdata[7:0]}};
                lane_mask = 8'b0000_0001 << addr[2:0];
            end
            MEM_H: begin
                lane_data = {4{wdata[15:0]}};
                lane_mask = 8'b0000_0011 << {addr[2:1], 1'b0};
            end
            MEM_W: begin
                lane_data = {2{wdata[31:0]}};
                lane_mask = addr[2] ? 8'hf0 : 8'h0f;
            end
            default: begin
                lane_data = wdata;
                lane_mask = 8'hff;
            end
        endcase
    end

    assign store.wr   = wr;
    assign store.addr = addr;
    assign store.data = lane_data;
    assign store.mask = wr ? lane_mask : 8'h00;

endmodule

/* verif/ex_stage_tb.sv */
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_stage_tb
    import ex_ctrl_pkg::*;
    import ex_data_pkg::*;
();

    localparam int NUM_INSTR   = 600;
    localparam int RST_TIMEOUT = 10;
    localparam int RUN_TIMEOUT = 5000;

    logic                clk;
    logic                rst_n      = 1'b0;
    logic                stall      = 1'b0;
    logic                in_valid   = 1'b0;
    logic                raise_intr = 1'b0;
    ex_issue_t           in_issue   = '0;
    logic                out_valid;
    ex_result_t          out_res;
    ex_jump_t            out_jump;
    ex_store_t           out_store;

    integer              seed        = 65;
    int                  reset_edges = 0;
    int                  stall_left  = 0;
    int                  n_captured  = 0;
    int                  wait_cycles;
    logic                m_loaded    = 1'b0; // Model holds a known issue word
    logic                m_valid     = 1'b0;
    ex_issue_t           m_issue;
    logic [`EX_XLEN-1:0] m_a;
    logic [`EX_XLEN-1:0] m_b;
    logic [`EX_XLEN-1:0] m_result;
    logic                exp_valid;
    ex_result_t          exp_res;
    ex_jump_t            exp_jump;
    ex_store_t           exp_store;

    ex_tb_clock u_clock (
        .clk (clk)
    );

    ex_stage i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .in_valid   (in_valid),
        .raise_intr (raise_intr),
        .in_issue   (in_issue),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_jump   (out_jump),
        .out_store  (out_store)
    );

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    function automatic logic [31:0] pick_below(input logic [31:0] n);
        pick_below = next_random() % n;
    endfunction

    function automatic ex_issue_t make_issue();
        ex_issue_t   t;
        logic [31:0] r;
        r = next_random();
        t.ctrl.alu_op   = alu_op_t'(4'(pick_below(11)));
        t.ctrl.word_op  = pick_below(4) == 0;
        t.ctrl.a_sel    = alu_a_sel_t'(1'(pick_below(2)));
        t.ctrl.b_sel    = alu_b_sel_t'(2'(pick_below(4)));
        t.ctrl.branch   = branch_t'(3'(pick_below(7)));
        t.ctrl.mem_rd   = pick_below(4) == 0;
        t.ctrl.mem_wr   = pick_below(3) == 0;
        t.ctrl.mem_size = mem_size_t'(2'(pick_below(4)));
        t.ctrl.reg_wr   = r[0];
        t.ctrl.rd       = r[`EX_REG_AW:1];
        t.ctrl.csr      = r[6];
        t.ctrl.csr_addr = r[`EX_CSR_AW+6:7];
        t.ctrl.ecall    = pick_below(4) == 0;
        t.ctrl.mret     = r[19];
        t.ctrl.fence_i  = pick_below(8) == 0;
        t.ctrl.error    = r[20];
        t.ops.src1      = {next_random(), next_random()};
        t.ops.src2      = (pick_below(4) == 0) ? t.ops.src1 : {next_random(), next_random()};
        t.ops.imm       = next_random();
        t.ops.csr_data  = {next_random(), next_random()};
        r = next_random();
        t.ops.pc        = {next_random(), r[31:2], 2'b00}; // Instruction aligned
        return t;
    endfunction

    function automatic logic [63:0] sign_extend_imm(input logic [31:0] imm);
        return imm[31] ? {32'hffff_ffff, imm} : {32'h0000_0000, imm};
    endfunction

    function automatic logic [63:0] compute_alu(input logic [63:0] a, input logic [63:0] b,
                                                input alu_op_t op, input logic w);
        logic [63:0] r;
        logic [63:0] fill;
        int          sh;
        sh   = w ? int'(b[4:0]) : int'(b[5:0]);
        fill = '0;
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a + ~b + 64'd1;
            ALU_SLL:  r = w ? {32'd0, a[31:0] << sh} : a << sh;
            ALU_SLT:  r = {63'd0, (a[63] != b[63]) ? a[63] : (a < b)}; // Sign decides first
            ALU_SLTU: r = {63'd0, a < b};
            ALU_XOR:  r = a ^ b;
            ALU_SRL:  r = w ? {32'd0, a[31:0] >> sh} : a >> sh;
            ALU_SRA: begin
                if (w) begin
                    if (a[31]) begin
                        fill = {32'd0, ~(32'hffff_ffff >> sh)};
                    end
                    r = {32'd0, a[31:0] >> sh} | fill;
                end else begin
                    if (a[63]) begin
                        fill = ~(64'hffff_ffff_ffff_ffff >> sh);
                    end
                    r = (a >> sh) | fill;
                end
            end
            ALU_OR:     r = a | b;
            ALU_AND:    r = a & b;
            ALU_PASS_B: r = b;
            default:    r = '0;
        endcase
        return w ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    function automatic ex_jump_t resolve_jump(input ex_issue_t t, input logic [63:0] res,
                                              input logic valid);
        ex_jump_t    j;
        logic [63:0] imm;
        logic [63:0] seq;
        logic        cond;
        imm = sign_extend_imm(t.ops.imm);
        seq = t.ops.pc + 64'd4;
        case (t.ctrl.branch)
            BR_BEQ:  cond = (res == '0);
            BR_BNE:  cond = (res != '0);
            BR_BLT:  cond = res[0];
            BR_BGE:  cond = !res[0];
            default: cond = 1'b0;
        endcase
        j.taken  = cond;
        j.target = cond ? t.ops.pc + imm : seq;
        if (t.ctrl.branch == BR_JAL) begin
            j.taken  = 1'b1;
            j.target = t.ops.pc + imm;
        end
        if (t.ctrl.branch == BR_JALR) begin
            j.taken  = 1'b1;
            j.target = (t.ops.src1 + imm) & ~64'd1;
        end
        if (t.ctrl.fence_i) begin
            j.taken  = 1'b1;
            j.target = seq;
        end
        j.taken = j.taken && valid;
        return j;
    endfunction

    // Lane i belongs to the access when it shares the access-sized block of addr
    function automatic ex_store_t format_store(input ex_issue_t t, input logic [63:0] addr,
                                               input logic valid);
        ex_store_t s;
        int        lg;
        int        i;
        lg     = int'(t.ctrl.mem_size);
        s.wr   = t.ctrl.mem_wr && valid;
        s.addr = addr;
        for (i = 0; i < 8; i++) begin
            s.data[8*i +: 8] = t.ops.src2[8*(i % (1 << lg)) +: 8];
            s.mask[i]        = s.wr && ((i >> lg) == (int'(addr[2:0]) >> lg));
        end
        return s;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_valid(input logic exp, input logic got);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t out_valid expected %b got %b", $time, exp, got));
        end
    endtask

    task automatic check_res(input ex_result_t exp, input ex_result_t got);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t out_res expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic check_jump(input ex_jump_t exp, input ex_jump_t got);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t out_jump expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic check_store(input ex_store_t exp, input ex_store_t got);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t out_store expected %h got %h", $time, exp, got));
        end
    endtask

    always @(posedge clk) begin
        if (!stall) begin
            m_issue  = in_issue; // Same values the issue register samples on this edge
            m_loaded = 1'b1;
        end
        if (!rst_n) begin
            m_valid = 1'b0;
        end else if (!stall) begin
            m_valid = in_valid;
            if (in_valid) begin
                n_captured = n_captured + 1;
            end
        end
        reset_edges = reset_edges + 1;
        if (reset_edges >= 2) begin
            rst_n <= 1'b1;
        end
        in_issue   <= make_issue();
        in_valid   <= pick_below(4) != 0;
        raise_intr <= pick_below(5) == 0;
        if (stall_left > 0) begin
            stall      <= 1'b1;
            stall_left = stall_left - 1;
        end else if (pick_below(6) == 0) begin
            stall      <= 1'b1;
            stall_left = int'(pick_below(5)); // Stretch of one to five cycles
        end else begin
            stall <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (m_loaded) begin
            m_a = (m_issue.ctrl.a_sel == A_PC) ? m_issue.ops.pc : m_issue.ops.src1;
            case (m_issue.ctrl.b_sel)
                B_RS2:   m_b = m_issue.ops.src2;
                B_FOUR:  m_b = 64'd4;
                B_IMM:   m_b = sign_extend_imm(m_issue.ops.imm);
                default: m_b = m_issue.ops.csr_data;
            endcase
            m_result = compute_alu(m_a, m_b, m_issue.ctrl.alu_op, m_issue.ctrl.word_op);
            exp_valid = m_valid && (m_issue.ctrl.ecall || !raise_intr);
            exp_res.result   = m_result;
            exp_res.rd       = m_issue.ctrl.rd;
            exp_res.reg_wr   = m_issue.ctrl.reg_wr;
            exp_res.csr      = m_issue.ctrl.csr;
            exp_res.csr_addr = m_issue.ctrl.csr_addr;
            exp_res.ecall    = m_issue.ctrl.ecall;
            exp_res.mret     = m_issue.ctrl.mret;
            exp_res.error    = m_issue.ctrl.error;
            exp_res.is_alu   = !m_issue.ctrl.mem_rd;
            exp_jump  = resolve_jump(m_issue, m_result, m_valid);
            exp_store = format_store(m_issue, m_result, m_valid);
            check_valid(exp_valid, out_valid);
            check_res(exp_res, out_res);
            check_jump(exp_jump, out_jump);
            check_store(exp_store, out_store);
        end
    end

    initial begin
        wait_cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > RST_TIMEOUT) begin
                stop_on_error($sformatf("Reset was not released within %0d cycles",
                                        RST_TIMEOUT));
            end
        end
        wait_cycles = 0;
        while (n_captured < NUM_INSTR) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > RUN_TIMEOUT) begin
                stop_on_error($sformatf("Only %0d of %0d instructions issued in %0d cycles",
                                        n_captured, NUM_INSTR, RUN_TIMEOUT));
            end
        end
        repeat (2) @(posedge clk); // Let the last captured slot be checked
        $display("Done: no errors");
        $finish;
    end

endmodule

/* verif/ex_tb_clock.sv */
`timescale 1ns/1ns

module ex_tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 20; // 40 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule
